//--- dv/board_monitor.sv
// board monitor
// decodes replies on the DUT serial output and checks LEDs
// against the expected values in the test data file
`default_nettype none

module board_monitor (
    input  logic                              mainclk_buf,
    input  logic                              arst_n_i,
    input  logic                              uart_tx_i,
    input  logic [board_pkg::USR_LED_W-1:0]   usrled_i,
    input  logic [board_pkg::CHERI_ERR_W-1:0] cherierr_i,
    input  logic                              led_legacy_i,
    input  logic                              led_cheri_i,
    input  logic                              led_halted_i,
    input  logic                              led_bootok_i,
    input  logic                              led_check_i,
    output int                                mismatch_count_o,
    output int                                other_count_o,
    output logic                              replies_done_o
);
    timeunit 1ns;
    timeprecision 1ps;

    import host_pkg::*;
    import board_pkg::*;

    localparam TESTDATA = "dv/board_testdata.txt";
    localparam int LED_W = USR_LED_W + CHERI_ERR_W + 4;

    logic [7:0]       reply_exp[$];
    int               led_mode[$];   // 0 exact, 1 all bits equal
    logic [LED_W-1:0] led_exp[$];
    int               replies_seen;
    int               replies_total;

    assign replies_done_o = (replies_seen == replies_total);

    task automatic load_expected();
        int               fd;
        int               code;
        logic [7:0]       op;
        int               a;
        int               v;
        logic [8*128-1:0] rest;
        fd = $fopen(TESTDATA, "r");
        if (fd == 0) begin
            $display("error: monitor cannot open the test data file %s", TESTDATA);
            other_count_o++;
            return;
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            if (op == "#") begin
                code = $fgets(rest, fd);
            end else begin
                code = $fscanf(fd, "%h %h", a, v);
                if (code != 2) begin
                    $display("error: monitor found an incomplete test record, opcode %c", op);
                    other_count_o++;
                end
                if (op == "R") begin
                    reply_exp.push_back(8'(v));
                end else if (op == "L") begin
                    led_mode.push_back(a);
                    led_exp.push_back(LED_W'(v));
                end
            end
        end
        $fclose(fd);
        replies_total = reply_exp.size();
    endtask

    // called at the first low sample of a start bit
    task automatic receive_reply();
        logic [7:0] data;
        logic [7:0] exp;
        repeat (CLKS_PER_BIT / 2 - 1) @(negedge mainclk_buf);  // to mid start bit
        if (uart_tx_i !== 1'b0) begin
            $display("error: start bit on uart_tx too short at %0t", $time);
            other_count_o++;
            return;
        end
        for (int i = 0; i < DATA_BITS; i++) begin
            repeat (CLKS_PER_BIT) @(negedge mainclk_buf);
            data[i] = uart_tx_i;
        end
        repeat (CLKS_PER_BIT) @(negedge mainclk_buf);
        if (uart_tx_i !== 1'b1) begin
            $display("error: reply frame on uart_tx has no stop bit at %0t", $time);
            other_count_o++;
        end
        if (reply_exp.size() == 0) begin
            $display("error: reply byte %02h arrived with no read pending", data);
            other_count_o++;
        end else begin
            exp = reply_exp.pop_front();
            replies_seen++;
            if (data !== exp) begin
                $display("mismatch uart_tx reply: got %02h, expected %02h", data, exp);
                mismatch_count_o++;
            end
        end
    endtask

    task automatic check_leds();
        logic [LED_W-1:0] seen;
        logic [LED_W-1:0] exp;
        int               mode;
        @(negedge mainclk_buf);  // LEDs are stable mid-cycle
        seen = {led_bootok_i, led_halted_i, led_cheri_i, led_legacy_i, cherierr_i, usrled_i};
        if (led_exp.size() == 0) begin
            $display("error: LED check requested with no LED record left");
            other_count_o++;
            return;
        end
        mode = led_mode.pop_front();
        exp  = led_exp.pop_front();
        if (mode == 0) begin
            if (seen !== exp) begin
                $display("mismatch leds: got %06h, expected %06h", seen, exp);
                mismatch_count_o++;
            end
        end else if (seen !== '0 && seen !== '1) begin
            $display("mismatch leds: got %06h, expected %06h or %06h",
                     seen, {LED_W{1'b0}}, {LED_W{1'b1}});
            mismatch_count_o++;
        end
    endtask

    task automatic watch_tx();
        forever begin
            @(negedge mainclk_buf);
            if (arst_n_i && uart_tx_i === 1'b0) begin
                receive_reply();
            end
        end
    endtask

    task automatic watch_leds();
        forever begin
            @(posedge mainclk_buf);
            if (led_check_i === 1'b1) begin
                check_leds();
            end
        end
    endtask

    initial begin
        mismatch_count_o = 0;
        other_count_o    = 0;
        replies_seen     = 0;
        replies_total    = 0;
        load_expected();
        fork
            watch_tx();
            watch_leds();
        join
    end

endmodule

`default_nettype wire

//--- dv/board_tb.sv
// board management testbench
// plays UART commands and switch settings from the test data file
// into the DUT with random idle gaps between frames
`default_nettype none

module board_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import host_pkg::*;
    import board_pkg::*;

    localparam TESTDATA = "dv/board_testdata.txt";

    logic                   mainclk_buf;
    logic                   arst_n;
    logic                   uart_rx;
    logic                   uart_tx;
    logic [USR_SW_W-1:0]    usr_sw;
    logic [NAV_SW_W-1:0]    nav_sw;
    logic [SEL_SW_W-1:0]    sel_sw;
    logic [USR_LED_W-1:0]   usrled;
    logic [CHERI_ERR_W-1:0] cherierr;
    logic                   led_legacy;
    logic                   led_cheri;
    logic                   led_halted;
    logic                   led_bootok;
    logic                   led_check;   // tells the monitor to look at the LEDs

    int          mismatch_count;
    int          other_count;
    logic        replies_done;
    int          tb_errors;
    int          cycles;
    int          cycle_limit;
    logic [31:0] rng;

    logic [7:0] rec_op[$];
    int         rec_addr[$];
    int         rec_val[$];

    board_top board_top_i (
        .mainclk_buf  (mainclk_buf),
        .arst_n_i     (arst_n),
        .uart_rx_i    (uart_rx),
        .uart_tx_o    (uart_tx),
        .usr_sw_i     (usr_sw),
        .nav_sw_i     (nav_sw),
        .sel_sw_i     (sel_sw),
        .usrled_o     (usrled),
        .cherierr_o   (cherierr),
        .led_legacy_o (led_legacy),
        .led_cheri_o  (led_cheri),
        .led_halted_o (led_halted),
        .led_bootok_o (led_bootok)
    );

    board_monitor board_monitor_i (
        .mainclk_buf      (mainclk_buf),
        .arst_n_i         (arst_n),
        .uart_tx_i        (uart_tx),
        .usrled_i         (usrled),
        .cherierr_i       (cherierr),
        .led_legacy_i     (led_legacy),
        .led_cheri_i      (led_cheri),
        .led_halted_i     (led_halted),
        .led_bootok_i     (led_bootok),
        .led_check_i      (led_check),
        .mismatch_count_o (mismatch_count),
        .other_count_o    (other_count),
        .replies_done_o   (replies_done)
    );

    initial mainclk_buf = 1'b0;
    always #20 mainclk_buf = ~mainclk_buf;  // 40 ns period

    function automatic logic [31:0] next_rand(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic idle_bits(input int n);
        repeat (n * CLKS_PER_BIT) @(negedge mainclk_buf);
    endtask

    // one frame lsb first with the stop bit level given by the caller
    task automatic send_byte(input logic [7:0] data, input logic stop);
        logic [FRAME_BITS-1:0] frame;
        frame = {stop, data, 1'b0};
        for (int i = 0; i < FRAME_BITS; i++) begin
            @(negedge mainclk_buf);
            uart_rx = frame[i];
            repeat (CLKS_PER_BIT - 1) @(negedge mainclk_buf);
        end
        @(negedge mainclk_buf);
        uart_rx = 1'b1;
        rng = next_rand(rng);
        idle_bits(int'(rng[2:0]));  // gap of 0 to 7 bit periods
    endtask

    task automatic load_records();
        int               fd;
        int               code;
        logic [7:0]       op;
        int               a;
        int               v;
        logic [8*128-1:0] rest;
        fd = $fopen(TESTDATA, "r");
        if (fd == 0) begin
            $display("error: cannot open the test data file %s", TESTDATA);
            tb_errors++;
            return;
        end
        while ($fscanf(fd, " %c", op) == 1) begin
            if (op == "#") begin
                code = $fgets(rest, fd);  // skip comment line
            end else begin
                code = $fscanf(fd, "%h %h", a, v);
                if (code != 2) begin
                    $display("error: test record %0d with opcode %c is incomplete",
                             rec_op.size(), op);
                    tb_errors++;
                end
                rec_op.push_back(op);
                rec_addr.push_back(a);
                rec_val.push_back(v);
            end
        end
        $fclose(fd);
    endtask

    task automatic report_counts();
        $display("errors: %0d mismatch, %0d other", mismatch_count, other_count + tb_errors);
    endtask

    // run limit counted from reset release
    always @(posedge mainclk_buf) begin
        if (arst_n) begin
            cycles++;
            if (cycle_limit > 0 && cycles >= cycle_limit) begin
                $display("error: timeout, run did not finish within %0d cycles", cycle_limit);
                report_counts();
                $display("*** FAILED ***");
                $finish;
            end
        end
    end

    initial begin
        arst_n      = 1'b0;
        uart_rx     = 1'b1;
        usr_sw      = '0;
        nav_sw      = '0;
        sel_sw      = '0;
        led_check   = 1'b0;
        tb_errors   = 0;
        cycles      = 0;
        cycle_limit = 0;
        rng         = 32'h819f;
        load_records();
        if (rec_op.size() == 0) begin
            $display("error: no test records were read");
            tb_errors++;
        end
        cycle_limit = rec_op.size() * 30 * CLKS_PER_BIT;
        repeat (5) @(negedge mainclk_buf);
        arst_n = 1'b1;
        idle_bits(1);
        for (int i = 0; i < rec_op.size(); i++) begin
            case (rec_op[i])
                "W": begin
                    send_byte(8'h80 | 8'(rec_addr[i]), 1'b1);
                    send_byte(8'(rec_val[i]), 1'b1);
                end
                "R": send_byte(8'(rec_addr[i]) & 8'h7F, 1'b1);
                "S": begin
                    @(negedge mainclk_buf);
                    usr_sw           = USR_SW_W'(rec_addr[i]);
                    {nav_sw, sel_sw} = 8'(rec_val[i]);
                    idle_bits(2);  // let the synchronizers settle
                end
                "F": begin
                    send_byte(8'(rec_val[i]), 1'b0);
                    idle_bits(1);  // line must idle high before the next start bit
                end
                "L": begin
                    idle_bits(1);
                    @(negedge mainclk_buf);
                    led_check = 1'b1;
                    @(negedge mainclk_buf);
                    led_check = 1'b0;
                end
                default: begin
                    $display("error: unknown opcode in record %0d", i);
                    tb_errors++;
                end
            endcase
        end
        while (!replies_done) @(posedge mainclk_buf);  // last reply may still be on the line
        idle_bits(2);
        report_counts();
        if (mismatch_count + other_count + tb_errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- dv/board_testdata.txt
# op addr value (hex). W write, R read and expected reply, S switches usr=addr {nav,sel}=value
# F byte=value with low stop bit, L LEDs {bootok,halted,cheri,legacy,cherierr,usrled}, addr 1 = all equal
L 00 000000
R 00 5A
R 7F 00
R 09 00
W 08 A5
R 08 A5
W 00 33
R 00 5A
S 3C 9D
R 06 3C
R 07 9D
W 01 01
L 00 000004
R 01 01
W 03 5A
W 04 C3
W 05 F5
R 05 15
W 02 01
L 00 15C35A
R 02 01
W 02 03
L 01 000000
W 02 00
L 00 000004
F 00 55
L 00 000084
R 08 A5
W 01 00
L 00 000080
S A1 5E
R 06 A1
R 07 5E
W 08 3C
R 08 3C

//--- logic/board_pkg.sv
// board constants
// register map, switch and LED widths, heartbeat counter layout
`default_nettype none

package board_pkg;

    // register map
    localparam logic [host_pkg::REG_ADDR_W-1:0] REG_ID        = 'h00;
    localparam logic [host_pkg::REG_ADDR_W-1:0] REG_USER_LED  = 'h01;
    localparam logic [host_pkg::REG_ADDR_W-1:0] REG_LED_CTRL  = 'h02;  // [0] test, [1] flash
    localparam logic [host_pkg::REG_ADDR_W-1:0] REG_TEST_LED0 = 'h03;
    localparam logic [host_pkg::REG_ADDR_W-1:0] REG_TEST_LED1 = 'h04;
    localparam logic [host_pkg::REG_ADDR_W-1:0] REG_TEST_LED2 = 'h05;
    localparam logic [host_pkg::REG_ADDR_W-1:0] REG_SW_LO     = 'h06;
    localparam logic [host_pkg::REG_ADDR_W-1:0] REG_SW_HI     = 'h07;  // {nav, sel}
    localparam logic [host_pkg::REG_ADDR_W-1:0] REG_SCRATCH   = 'h08;

    localparam logic [7:0] BOARD_ID = 8'h5A;

    localparam int USR_SW_W = 8;
    localparam int NAV_SW_W = 5;
    localparam int SEL_SW_W = 3;
    localparam int SW_W     = USR_SW_W + NAV_SW_W + SEL_SW_W;

    // LED layout
    localparam int TEST_LED_W  = 21;
    localparam int USR_LED_W   = 8;
    localparam int CHERI_ERR_W = 9;

    localparam int HEARTBEAT_W = 25;
    localparam int FLASH_BIT   = 23;

endpackage

`default_nettype wire

//--- logic/board_regs.sv
// board register file
// writable control registers, synchronized switch readback, read mux
`default_nettype none

module board_regs (
    input  logic                              mainclk_buf,
    input  logic                              arst_n_i,
    input  logic [host_pkg::REG_ADDR_W-1:0]   reg_addr_i,
    input  logic [7:0]                        reg_wdata_i,
    input  logic                              reg_write_i,
    input  logic                              reg_read_i,
    input  logic [board_pkg::USR_SW_W-1:0]    usr_sw_i,
    input  logic [board_pkg::NAV_SW_W-1:0]    nav_sw_i,
    input  logic [board_pkg::SEL_SW_W-1:0]    sel_sw_i,
    output logic [7:0]                        reg_rdata_o,
    output logic                              user_led_o,
    output logic                              test_mode_o,
    output logic                              flash_all_o,
    output logic [board_pkg::TEST_LED_W-1:0]  test_leds_o
);
    import board_pkg::*;

    logic [USR_LED_W-1:0] user_led;
    logic [1:0]           led_ctrl;
    logic [7:0]           scratch;
    logic [SW_W-1:0]      sw_meta;
    logic [SW_W-1:0]      sw_sync;  // {usr, nav, sel}

    always_ff @(posedge mainclk_buf or negedge arst_n_i) begin
        if (!arst_n_i) begin
            sw_meta <= '0;
            sw_sync <= '0;
        end else begin
            sw_meta <= {usr_sw_i, nav_sw_i, sel_sw_i};
            sw_sync <= sw_meta;
        end
    end

    always_ff @(posedge mainclk_buf or negedge arst_n_i) begin
        if (!arst_n_i) begin
            user_led    <= '0;
            led_ctrl    <= '0;
            test_leds_o <= '0;
            scratch     <= '0;
        end else if (reg_write_i) begin
            case (reg_addr_i)
                REG_USER_LED:  user_led           <= reg_wdata_i;
                REG_LED_CTRL:  led_ctrl           <= reg_wdata_i[1:0];
                REG_TEST_LED0: test_leds_o[7:0]   <= reg_wdata_i;
                REG_TEST_LED1: test_leds_o[15:8]  <= reg_wdata_i;
                REG_TEST_LED2: test_leds_o[TEST_LED_W-1:16] <= reg_wdata_i[TEST_LED_W-17:0];
                REG_SCRATCH:   scratch            <= reg_wdata_i;
                default: ;  // id, switches and holes are read-only
            endcase
        end
    end

    always_comb begin
        case (reg_addr_i)
            REG_ID:        reg_rdata_o = BOARD_ID;
            REG_USER_LED:  reg_rdata_o = user_led;
            REG_LED_CTRL:  reg_rdata_o = 8'(led_ctrl);
            REG_TEST_LED0: reg_rdata_o = test_leds_o[7:0];
            REG_TEST_LED1: reg_rdata_o = test_leds_o[15:8];
            REG_TEST_LED2: reg_rdata_o = 8'(test_leds_o[TEST_LED_W-1:16]);
            REG_SW_LO:     reg_rdata_o = sw_sync[SW_W-1 -: USR_SW_W];
            REG_SW_HI:     reg_rdata_o = sw_sync[NAV_SW_W+SEL_SW_W-1:0];
            REG_SCRATCH:   reg_rdata_o = scratch;
            default:       reg_rdata_o = '0;
        endcase
    end

    assign user_led_o  = user_led[0];
    assign test_mode_o = led_ctrl[0];
    assign flash_all_o = led_ctrl[1];

    // the decoder issues one strobe per received command
    a_no_read_write: assert property (
        @(posedge mainclk_buf) disable iff (!arst_n_i)
        reg_write_i |-> !reg_read_i
    );

endmodule

`default_nettype wire

//--- logic/board_top.sv
// board management top level
// UART host link, command decoder, register file and LED driver
`default_nettype none

module board_top (
    input  logic                               mainclk_buf,
    input  logic                               arst_n_i,
    input  logic                               uart_rx_i,
    output logic                               uart_tx_o,
    input  logic [board_pkg::USR_SW_W-1:0]     usr_sw_i,
    input  logic [board_pkg::NAV_SW_W-1:0]     nav_sw_i,
    input  logic [board_pkg::SEL_SW_W-1:0]     sel_sw_i,
    output logic [board_pkg::USR_LED_W-1:0]    usrled_o,
    output logic [board_pkg::CHERI_ERR_W-1:0]  cherierr_o,
    output logic                               led_legacy_o,
    output logic                               led_cheri_o,
    output logic                               led_halted_o,
    output logic                               led_bootok_o
);
    import host_pkg::*;
    import board_pkg::*;

    logic [DATA_BITS-1:0]  rx_data;
    logic                  rx_valid;
    logic [DATA_BITS-1:0]  tx_data;
    logic                  tx_start;
    logic                  tx_busy;
    logic                  frame_err;

    logic [REG_ADDR_W-1:0] reg_addr;
    logic [DATA_BITS-1:0]  reg_wdata;
    logic [DATA_BITS-1:0]  reg_rdata;
    logic                  reg_write;
    logic                  reg_read;

    logic                  user_led;
    logic                  test_mode;
    logic                  flash_all;
    logic [TEST_LED_W-1:0] test_leds;

    uart_link uart_link_i (
        .mainclk_buf (mainclk_buf),
        .arst_n_i    (arst_n_i),
        .rx_i        (uart_rx_i),
        .tx_o        (uart_tx_o),
        .tx_data_i   (tx_data),
        .tx_start_i  (tx_start),
        .rx_data_o   (rx_data),
        .rx_valid_o  (rx_valid),
        .tx_busy_o   (tx_busy),
        .frame_err_o (frame_err)
    );

    host_cmd_fsm host_cmd_fsm_i (
        .mainclk_buf (mainclk_buf),
        .arst_n_i    (arst_n_i),
        .rx_data_i   (rx_data),
        .rx_valid_i  (rx_valid),
        .tx_busy_i   (tx_busy),
        .tx_data_o   (tx_data),
        .tx_start_o  (tx_start),
        .reg_addr_o  (reg_addr),
        .reg_wdata_o (reg_wdata),
        .reg_write_o (reg_write),
        .reg_read_o  (reg_read),
        .reg_rdata_i (reg_rdata)
    );

    board_regs board_regs_i (
        .mainclk_buf (mainclk_buf),
        .arst_n_i    (arst_n_i),
        .reg_addr_i  (reg_addr),
        .reg_wdata_i (reg_wdata),
        .reg_write_i (reg_write),
        .reg_read_i  (reg_read),
        .usr_sw_i    (usr_sw_i),
        .nav_sw_i    (nav_sw_i),
        .sel_sw_i    (sel_sw_i),
        .reg_rdata_o (reg_rdata),
        .user_led_o  (user_led),
        .test_mode_o (test_mode),
        .flash_all_o (flash_all),
        .test_leds_o (test_leds)
    );

    led_status led_status_i (
        .mainclk_buf  (mainclk_buf),
        .arst_n_i     (arst_n_i),
        .user_led_i   (user_led),
        .test_mode_i  (test_mode),
        .flash_all_i  (flash_all),
        .test_leds_i  (test_leds),
        .link_err_i   (frame_err),  // sticky framing error
        .usrled_o     (usrled_o),
        .cherierr_o   (cherierr_o),
        .led_legacy_o (led_legacy_o),
        .led_cheri_o  (led_cheri_o),
        .led_halted_o (led_halted_o),
        .led_bootok_o (led_bootok_o)
    );

endmodule

`default_nettype wire

//--- logic/host_cmd_fsm.sv
// host command decoder
// turns received bytes into register strobes and sends read replies,
// holding one reply while the transmitter is busy
`default_nettype none

module host_cmd_fsm (
    input  logic                            mainclk_buf,
    input  logic                            arst_n_i,
    input  logic [host_pkg::DATA_BITS-1:0]  rx_data_i,
    input  logic                            rx_valid_i,
    input  logic                            tx_busy_i,
    output logic [host_pkg::DATA_BITS-1:0]  tx_data_o,
    output logic                            tx_start_o,
    output logic [host_pkg::REG_ADDR_W-1:0] reg_addr_o,
    output logic [host_pkg::DATA_BITS-1:0]  reg_wdata_o,
    output logic                            reg_write_o,
    output logic                            reg_read_o,
    input  logic [host_pkg::DATA_BITS-1:0]  reg_rdata_i
);
    import host_pkg::*;

    logic                 want_data;  // second state, data byte of a write
    logic                 q_valid;
    logic [DATA_BITS-1:0] q_data;

    always_ff @(posedge mainclk_buf or negedge arst_n_i) begin
        if (!arst_n_i) begin
            want_data   <= 1'b0;
            reg_addr_o  <= '0;
            reg_wdata_o <= '0;
            reg_write_o <= 1'b0;
            reg_read_o  <= 1'b0;
        end else begin
            reg_write_o <= 1'b0;
            reg_read_o  <= 1'b0;
            if (rx_valid_i) begin
                if (!want_data) begin
                    reg_addr_o <= rx_data_i[REG_ADDR_W-1:0];
                    if (rx_data_i[CMD_WRITE_BIT]) begin
                        want_data <= 1'b1;
                    end else begin
                        reg_read_o <= 1'b1;
                    end
                end else begin
                    reg_wdata_o <= rx_data_i;
                    reg_write_o <= 1'b1;
                    want_data   <= 1'b0;
                end
            end
        end
    end

    // queued byte goes first, a fresh read goes straight out if the line is free
    assign tx_start_o = !tx_busy_i && (q_valid || reg_read_o);
    assign tx_data_o  = q_valid ? q_data : reg_rdata_i;

    always_ff @(posedge mainclk_buf or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_valid <= 1'b0;
        end else if (tx_start_o) begin
            q_valid <= q_valid && reg_read_o;  // new reply takes the freed slot
        end else if (reg_read_o) begin
            q_valid <= 1'b1;  // when already full the reply is dropped
        end
    end

    always_ff @(posedge mainclk_buf) begin
        if (reg_read_o && (!q_valid || tx_start_o)) begin
            q_data <= reg_rdata_i;
        end
    end

    a_one_strobe: assert property (
        @(posedge mainclk_buf) disable iff (!arst_n_i)
        !(reg_read_o && reg_write_o)
    );

endmodule

`default_nettype wire

//--- logic/host_pkg.sv
// host link constants
// serial framing of the UART link and the layout of the command byte
`default_nettype none

package host_pkg;

    // bit period in main clocks, short for simulation (board uses 109)
    localparam int CLKS_PER_BIT = 16;
    localparam int BIT_CNT_W    = $clog2(CLKS_PER_BIT);

    localparam int DATA_BITS  = 8;
    localparam int FRAME_BITS = DATA_BITS + 2;  // start + data + stop

    // command byte, bit 7 set means write, low bits are the address
    localparam int CMD_WRITE_BIT = 7;
    localparam int REG_ADDR_W    = 7;

endpackage

`default_nettype wire

//--- logic/led_status.sv
// board LED driver
// heartbeat counter plus selection between status and test pattern
`default_nettype none

module led_status (
    input  logic                               mainclk_buf,
    input  logic                               arst_n_i,
    input  logic                               user_led_i,
    input  logic                               test_mode_i,
    input  logic                               flash_all_i,
    input  logic [board_pkg::TEST_LED_W-1:0]   test_leds_i,
    input  logic                               link_err_i,
    output logic [board_pkg::USR_LED_W-1:0]    usrled_o,
    output logic [board_pkg::CHERI_ERR_W-1:0]  cherierr_o,
    output logic                               led_legacy_o,
    output logic                               led_cheri_o,
    output logic                               led_halted_o,
    output logic                               led_bootok_o
);
    import board_pkg::*;

    logic [HEARTBEAT_W-1:0] heartbeat;
    logic                   flash;

    assign flash = heartbeat[FLASH_BIT];

    always_ff @(posedge mainclk_buf or negedge arst_n_i) begin
        if (!arst_n_i) begin
            heartbeat  <= '0;
            usrled_o   <= '0;
            cherierr_o <= '0;
            {led_bootok_o, led_halted_o, led_cheri_o, led_legacy_o} <= '0;
        end else begin
            heartbeat <= heartbeat + 1'b1;
            if (test_mode_i && flash_all_i) begin
                usrled_o   <= {USR_LED_W{flash}};
                cherierr_o <= {CHERI_ERR_W{flash}};
                {led_bootok_o, led_halted_o, led_cheri_o, led_legacy_o} <= {4{flash}};
            end else if (test_mode_i) begin
                usrled_o   <= test_leds_i[USR_LED_W-1:0];
                cherierr_o <= test_leds_i[USR_LED_W +: CHERI_ERR_W];
                // top four pattern bits, legacy first
                {led_bootok_o, led_halted_o, led_cheri_o, led_legacy_o} <=
                    test_leds_i[TEST_LED_W-1 -: 4];
            end else begin
                // status: error, user led, heartbeat
                usrled_o   <= {link_err_i, 4'b0, user_led_i, 1'b0, heartbeat[HEARTBEAT_W-1]};
                cherierr_o <= '0;
                {led_bootok_o, led_halted_o, led_cheri_o, led_legacy_o} <= '0;
            end
        end
    end

endmodule

`default_nettype wire

//--- logic/uart_link.sv
// UART link, 8N1 at a fixed bit period
// receiver samples mid-bit and latches framing errors,
// transmitter shifts a whole frame from its own register
`default_nettype none

module uart_link (
    input  logic                           mainclk_buf,
    input  logic                           arst_n_i,
    input  logic                           rx_i,
    output logic                           tx_o,
    input  logic [host_pkg::DATA_BITS-1:0] tx_data_i,
    input  logic                           tx_start_i,
    output logic [host_pkg::DATA_BITS-1:0] rx_data_o,
    output logic                           rx_valid_o,
    output logic                           tx_busy_o,
    output logic                           frame_err_o
);
    import host_pkg::*;

    logic [2:0]            rx_sync;   // two sync flops plus one for edge detect
    logic                  rx_s;
    logic                  rx_active;
    logic                  rx_tick;
    logic [3:0]            rx_bit;    // 0 start, 1..8 data, 9 stop
    logic [BIT_CNT_W-1:0]  rx_cnt;
    logic [DATA_BITS-1:0]  rx_shift;

    logic [FRAME_BITS-1:0] tx_shift;
    logic [3:0]            tx_bits;
    logic [BIT_CNT_W-1:0]  tx_cnt;

    assign rx_s    = rx_sync[1];
    assign rx_tick = rx_active && (rx_cnt == '0);

    always_ff @(posedge mainclk_buf or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rx_sync     <= 3'b111;  // line idles high
            rx_active   <= 1'b0;
            rx_bit      <= '0;
            rx_cnt      <= '0;
            rx_valid_o  <= 1'b0;
            frame_err_o <= 1'b0;
        end else begin
            rx_sync    <= {rx_sync[1:0], rx_i};
            rx_valid_o <= 1'b0;
            if (!rx_active) begin
                if (rx_sync[2] && !rx_s) begin  // falling edge
                    rx_active <= 1'b1;
                    rx_bit    <= '0;
                    rx_cnt    <= BIT_CNT_W'(CLKS_PER_BIT / 2 - 1);
                end
            end else if (!rx_tick) begin
                rx_cnt <= rx_cnt - 1'b1;
            end else begin
                rx_cnt <= BIT_CNT_W'(CLKS_PER_BIT - 1);
                rx_bit <= rx_bit + 1'b1;
                if (rx_bit == '0) begin
                    rx_active <= !rx_s;  // glitch, drop it
                end else if (rx_bit == 4'(FRAME_BITS - 1)) begin
                    rx_active   <= 1'b0;
                    rx_valid_o  <= rx_s;
                    frame_err_o <= frame_err_o | !rx_s;  // sticky until reset
                end
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge mainclk_buf) begin
        if (rx_tick && rx_bit != '0 && rx_bit < 4'(FRAME_BITS - 1)) begin
            rx_shift <= {rx_s, rx_shift[DATA_BITS-1:1]};
        end
    end

    assign rx_data_o = rx_shift;

    assign tx_o = tx_shift[0];

    always_ff @(posedge mainclk_buf or negedge arst_n_i) begin
        if (!arst_n_i) begin
            tx_shift  <= '1;
            tx_bits   <= '0;
            tx_cnt    <= '0;
            tx_busy_o <= 1'b0;
        end else if (tx_start_i && !tx_busy_o) begin
            tx_shift  <= {1'b1, tx_data_i, 1'b0};  // stop, data, start
            tx_bits   <= 4'(FRAME_BITS);
            tx_cnt    <= BIT_CNT_W'(CLKS_PER_BIT - 1);
            tx_busy_o <= 1'b1;
        end else if (tx_busy_o) begin
            if (tx_cnt != '0) begin
                tx_cnt <= tx_cnt - 1'b1;
            end else begin
                tx_cnt    <= BIT_CNT_W'(CLKS_PER_BIT - 1);
                tx_shift  <= {1'b1, tx_shift[FRAME_BITS-1:1]};
                tx_bits   <= tx_bits - 1'b1;
                tx_busy_o <= (tx_bits != 4'd1);  // last bit period done
            end
        end
    end

    // the command FSM must hold its reply while a frame is going out
    a_no_start_when_busy: assert property (
        @(posedge mainclk_buf) disable iff (!arst_n_i)
        tx_start_i |-> !tx_busy_o
    );

endmodule

`default_nettype wire

//--- sim.f
logic/host_pkg.sv
logic/board_pkg.sv
logic/uart_link.sv
logic/host_cmd_fsm.sv
logic/board_regs.sv
logic/led_status.sv
logic/board_top.sv
dv/board_monitor.sv
dv/board_tb.sv
